//--- Makefile
TOP = exeTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "=== PASS ===" > /dev/null

clean:
	rm -rf obj_dir

//--- list.f
src/cpuPkg.sv
src/mulDivIf.sv
src/stageReg.sv
src/alu.sv
src/branchSolve.sv
src/mulDivUnit.sv
src/exeStage.sv
src/exeTop.sv
tb/exeTop_asserts.sv
tb/exeTb.sv

//--- src/alu.sv
module alu import cpuPkg::*; (
    input  logic [dataW-1:0] a,
    input  logic [dataW-1:0] b,
    input  aluOpT            op,
    output logic [dataW-1:0] y,
    output logic             overflow
);

    logic [dataW-1:0] sum;
    logic [dataW-1:0] diff;
    logic [4:0]       sa;

    assign sum  = a + b;
    assign diff = a - b;
    assign sa   = a[4:0];    // shift amount rides on operand a

    always_comb begin
        y        = '0;
        overflow = 1'b0;
        case (op)
            opAdd: begin
                y = sum;
                // same signs in, different sign out
                overflow = (a[dataW-1] == b[dataW-1]) && (sum[dataW-1] != a[dataW-1]);
            end
            opAddu: y = sum;
            opSub: begin
                y = diff;
                overflow = (a[dataW-1] != b[dataW-1]) && (diff[dataW-1] != a[dataW-1]);
            end
            opSubu: y = diff;
            opAnd:  y = a & b;
            opOr:   y = a | b;
            opXor:  y = a ^ b;
            opNor:  y = ~(a | b);
            opSlt:  y = dataW'($signed(a) < $signed(b));
            opSltu: y = dataW'(a < b);
            opSll:  y = b << sa;
            opSrl:  y = b >> sa;
            opSra:  y = $signed(b) >>> sa;
            opLui:  y = {b[15:0], 16'b0};
            default: begin
                y = '0;    // mult/div results come back through hi/lo
            end
        endcase
    end

endmodule

//--- src/branchSolve.sv
module branchSolve import cpuPkg::*; (
    input  logic             valid,
    input  logic [dataW-1:0] pc,
    input  logic [dataW-1:0] busA,
    input  logic [dataW-1:0] busB,
    input  logic [dataW-1:0] imm32,
    input  branchT           branchType,
    input  logic             predTaken,
    input  logic [dataW-1:0] predTarget,
    output logic             predictionFailed,
    output logic [dataW-1:0] correctionVector
);

    logic             taken;
    logic [dataW-1:0] target;
    logic [dataW-1:0] pcAdd4;
    logic [dataW-1:0] pcAdd8;

    assign pcAdd4 = pc + dataW'(4);
    assign pcAdd8 = pc + dataW'(8);

    always_comb begin
        case (branchType)
            brBeq:   taken = (busA == busB);
            brBne:   taken = (busA != busB);
            brJump:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // word offset relative to the delay slot
    assign target = (branchType == brJump) ? busA : pcAdd4 + (imm32 << 2);

    // wrong direction, or right direction but wrong place
    assign predictionFailed = valid &&
                              ((taken != predTaken) || (taken && (target != predTarget)));

    assign correctionVector = !valid ? '0 : (taken ? target : pcAdd8);

endmodule

//--- src/cpuPkg.sv
package cpuPkg;

    localparam int dataW    = 32;
    localparam int regAddrW = 5;

    typedef enum logic [3:0] {
        opAdd,
        opAddu,
        opSub,
        opSubu,
        opAnd,
        opOr,
        opXor,
        opNor,
        opSlt,
        opSltu,
        opSll,
        opSrl,
        opSra,
        opLui,
        opMult,   // goes to mulDivUnit
        opDiv     // goes to mulDivUnit
    } aluOpT;

    typedef enum logic [1:0] {
        brNone,
        brBeq,
        brBne,
        brJump    // jr style, target from busA
    } branchT;

    typedef enum logic [1:0] {
        dstRd,
        dstRt,
        dstRa     // link register 31
    } dstSelT;

    typedef enum logic [1:0] {
        wbAlu,
        wbHi,
        wbLo,
        wbPcAdd8
    } wbSelT;

    // decoded instruction held in the ID/EXE register
    typedef struct packed {
        logic                valid;
        logic [dataW-1:0]    pc;
        logic [dataW-1:0]    busA;
        logic [dataW-1:0]    busB;
        logic [dataW-1:0]    imm32;
        logic [4:0]          shamt;
        logic [regAddrW-1:0] rt;
        logic [regAddrW-1:0] rd;
        aluOpT               aluOp;
        logic                srcBImm;
        logic                useShamt;
        dstSelT              dstSel;
        wbSelT               wbSel;
        logic                regWr;
        branchT              branchType;
        logic                predTaken;
        logic [dataW-1:0]    predTarget;
    } idExeT;

    typedef struct packed {
        logic                valid;
        logic [dataW-1:0]    pc;
        logic [dataW-1:0]    result;
        logic [regAddrW-1:0] dst;
        logic                regWr;
        logic                overflow;
    } exeMemT;

endpackage

//--- src/exeStage.sv
module exeStage import cpuPkg::*; (
    input  logic             clk,
    input  logic             arstN,
    input  idExeT            ex,
    input  logic             flush,
    mulDivIf.exe             md,
    output exeMemT           out,
    output logic             predictionFailed,
    output logic [dataW-1:0] correctionVector,
    output logic             mulDivStall
);

    logic [dataW-1:0] opA;
    logic [dataW-1:0] opB;
    logic [dataW-1:0] aluY;
    logic             aluOverflow;
    logic             isMulDiv;
    logic             reqSent;

    assign isMulDiv = ex.valid && ((ex.aluOp == opMult) || (ex.aluOp == opDiv));

    assign opA = ex.useShamt ? dataW'(ex.shamt) : ex.busA;
    assign opB = ex.srcBImm ? ex.imm32 : ex.busB;

    alu uAlu (
        .a        (opA),
        .b        (opB),
        .op       (ex.aluOp),
        .y        (aluY),
        .overflow (aluOverflow)
    );

    branchSolve uBranchSolve (
        .valid            (ex.valid),
        .pc               (ex.pc),
        .busA             (ex.busA),
        .busB             (ex.busB),
        .imm32            (ex.imm32),
        .branchType       (ex.branchType),
        .predTaken        (ex.predTaken),
        .predTarget       (ex.predTarget),
        .predictionFailed (predictionFailed),
        .correctionVector (correctionVector)
    );

    // one request per mul/div instruction
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            reqSent <= 1'b0;
        end else if (flush || md.done) begin
            reqSent <= 1'b0;
        end else if (md.start) begin
            reqSent <= 1'b1;
        end
    end

    assign md.start = isMulDiv && !md.busy && !md.done && !reqSent && !flush;
    assign md.op    = ex.aluOp;
    assign md.srcA  = ex.busA;
    assign md.srcB  = ex.busB;

    assign mulDivStall = isMulDiv && !md.done;

    always_comb begin
        out.valid = ex.valid;
        out.pc    = ex.pc;
        case (ex.wbSel)
            wbHi:     out.result = md.hi;
            wbLo:     out.result = md.lo;
            wbPcAdd8: out.result = ex.pc + dataW'(8);    // link address
            default:  out.result = aluY;
        endcase
        case (ex.dstSel)
            dstRt:   out.dst = ex.rt;
            dstRa:   out.dst = regAddrW'(31);
            default: out.dst = ex.rd;
        endcase
        out.overflow = aluOverflow;
        // no gpr write on overflow trap or for mult/div
        out.regWr    = ex.regWr && !aluOverflow && !isMulDiv;
    end

endmodule

//--- src/exeTop.sv
module exeTop import cpuPkg::*; #(
    parameter int mulDivCycles = 32
) (
    input  logic                clk,
    input  logic                arstN,
    input  logic                exeFlush,
    input  logic                exeWr,
    input  logic                idValid,
    input  logic [dataW-1:0]    idPc,
    input  logic [dataW-1:0]    idBusA,
    input  logic [dataW-1:0]    idBusB,
    input  logic [dataW-1:0]    idImm32,
    input  logic [4:0]          idShamt,
    input  logic [regAddrW-1:0] idRt,
    input  logic [regAddrW-1:0] idRd,
    input  aluOpT               idAluOp,
    input  logic                idSrcBImm,
    input  logic                idUseShamt,
    input  dstSelT              idDstSel,
    input  wbSelT               idWbSel,
    input  logic                idRegWr,
    input  branchT              idBranchType,
    input  logic                idPredTaken,
    input  logic [dataW-1:0]    idPredTarget,
    output logic                memValid,
    output logic [dataW-1:0]    memPc,
    output logic [dataW-1:0]    memResult,
    output logic [regAddrW-1:0] memDst,
    output logic                memRegWr,
    output logic                memOverflow,
    output logic                predictionFailed,
    output logic [dataW-1:0]    correctionVector,
    output logic                mulDivStall
);

    idExeT  idIn;
    idExeT  exIn;
    exeMemT exeOut;
    exeMemT memOut;

    mulDivIf mdBus ();

    assign idIn = '{
        valid:      idValid,
        pc:         idPc,
        busA:       idBusA,
        busB:       idBusB,
        imm32:      idImm32,
        shamt:      idShamt,
        rt:         idRt,
        rd:         idRd,
        aluOp:      idAluOp,
        srcBImm:    idSrcBImm,
        useShamt:   idUseShamt,
        dstSel:     idDstSel,
        wbSel:      idWbSel,
        regWr:      idRegWr,
        branchType: idBranchType,
        predTaken:  idPredTaken,
        predTarget: idPredTarget
    };

    stageReg #(.payloadT(idExeT)) uIdExe (
        .clk   (clk),
        .arstN (arstN),
        .flush (exeFlush),
        .load  (exeWr),
        .d     (idIn),
        .q     (exIn)
    );

    exeStage uExeStage (
        .clk              (clk),
        .arstN            (arstN),
        .ex               (exIn),
        .flush            (exeFlush),
        .md               (mdBus.exe),
        .out              (exeOut),
        .predictionFailed (predictionFailed),
        .correctionVector (correctionVector),
        .mulDivStall      (mulDivStall)
    );

    mulDivUnit #(.mulDivCycles(mulDivCycles)) uMulDiv (
        .clk   (clk),
        .arstN (arstN),
        .flush (exeFlush),
        .bus   (mdBus.unit)
    );

    // bubbles go downstream while mul/div is busy
    stageReg #(.payloadT(exeMemT)) uExeMem (
        .clk   (clk),
        .arstN (arstN),
        .flush (mulDivStall),
        .load  (!mulDivStall),
        .d     (exeOut),
        .q     (memOut)
    );

    assign memValid    = memOut.valid;
    assign memPc       = memOut.pc;
    assign memResult   = memOut.result;
    assign memDst      = memOut.dst;
    assign memRegWr    = memOut.regWr;
    assign memOverflow = memOut.overflow;

endmodule

//--- src/mulDivIf.sv
interface mulDivIf import cpuPkg::*; ();

    logic             start;   // one cycle request
    aluOpT            op;
    logic [dataW-1:0] srcA;
    logic [dataW-1:0] srcB;
    logic             busy;
    logic             done;    // hi/lo just written
    logic [dataW-1:0] hi;
    logic [dataW-1:0] lo;

    modport exe (
        output start, op, srcA, srcB,
        input  busy, done, hi, lo
    );

    modport unit (
        input  start, op, srcA, srcB,
        output busy, done, hi, lo
    );

endinterface

//--- src/mulDivUnit.sv
module mulDivUnit import cpuPkg::*; #(
    parameter int mulDivCycles = 32
) (
    input logic   clk,
    input logic   arstN,
    input logic   flush,
    mulDivIf.unit bus
);

    localparam int cntW = $clog2(mulDivCycles + 1);

    logic [cntW-1:0]    cnt;
    logic               busy;
    logic               done;
    logic               finish;
    logic               step;
    logic               isDiv;
    logic [dataW-1:0]   accHi;     // product high / partial remainder
    logic [dataW-1:0]   accLo;     // product low / quotient
    logic [2*dataW-1:0] mcand;     // multiplicand, shifts left
    logic [dataW-1:0]   opB;       // multiplier or divisor
    logic [dataW:0]     remTry;
    logic [2*dataW-1:0] prodSum;
    logic [dataW-1:0]   hiReg;
    logic [dataW-1:0]   loReg;

    assign finish  = busy && (cnt == '0) && !flush;
    assign step    = busy && (cnt != '0);
    assign remTry  = {accHi, accLo[dataW-1]};    // next dividend bit shifted in
    assign prodSum = {accHi, accLo} + mcand;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= finish;
            if (flush || finish) begin
                busy <= 1'b0;    // abort or complete
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end else if (bus.start) begin
                busy <= 1'b1;
                cnt  <= cntW'(mulDivCycles);
            end
        end
    end

    // one iteration per busy cycle
    always_ff @(posedge clk) begin
        if (bus.start && !busy) begin
            isDiv <= (bus.op == opDiv);
            opB   <= bus.srcB;
            accHi <= '0;
            if (bus.op == opDiv) begin
                // dividend sits high so a short run still consumes it all
                accLo <= bus.srcA << (dataW - mulDivCycles);
                mcand <= '0;
            end else begin
                accLo <= '0;
                mcand <= {{dataW{1'b0}}, bus.srcA};
            end
        end else if (step) begin
            if (isDiv) begin
                if (remTry >= {1'b0, opB}) begin
                    accHi <= dataW'(remTry - {1'b0, opB});
                    accLo <= {accLo[dataW-2:0], 1'b1};
                end else begin
                    accHi <= remTry[dataW-1:0];
                    accLo <= {accLo[dataW-2:0], 1'b0};
                end
            end else begin
                if (opB[0]) begin
                    {accHi, accLo} <= prodSum;
                end
                mcand <= mcand << 1;
                opB   <= opB >> 1;
            end
        end
    end

    // remainder and quotient land where the product halves do
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hiReg <= '0;
            loReg <= '0;
        end else if (finish) begin
            hiReg <= accHi;
            loReg <= accLo;
        end
    end

    assign bus.busy = busy;
    assign bus.done = done;
    assign bus.hi   = hiReg;
    assign bus.lo   = loReg;

endmodule

//--- src/stageReg.sv
module stageReg #(
    parameter type payloadT = logic [7:0]
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    flush,
    input  logic    load,
    input  payloadT d,
    output payloadT q
);

    // flush wins over load, an all zero payload is a bubble
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (load) begin
            q <= d;
        end
    end

endmodule

//--- tb/exeTb.sv
module exeTb import cpuPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int mulDivCycles = 32;

    // one instruction plus what the mem stage should show for it
    typedef struct packed {
        aluOpT       op;
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [4:0]  shamt;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic        srcBImm;
        logic        useShamt;
        logic        regWr;
        dstSelT      dstSel;
        wbSelT       wbSel;
        branchT      br;
        logic        predTaken;
        logic [31:0] predTarget;
        int          flushAt;      // cycles after issue, 0 means no flush
        logic        chkRes;
        logic [31:0] expResult;
        logic [4:0]  expDst;
        logic        expRegWr;
        logic        expOvf;
        logic        expPredFail;
        logic [31:0] expCorr;
        logic        expStall;     // stall seen in the cycle after issue
    } entryT;

    logic        clk;
    logic        arstN;
    logic        exeFlush;
    logic        exeWr;
    logic        idValid;
    logic [31:0] idPc;
    logic [31:0] idBusA;
    logic [31:0] idBusB;
    logic [31:0] idImm32;
    logic [4:0]  idShamt;
    logic [4:0]  idRt;
    logic [4:0]  idRd;
    aluOpT       idAluOp;
    logic        idSrcBImm;
    logic        idUseShamt;
    dstSelT      idDstSel;
    wbSelT       idWbSel;
    logic        idRegWr;
    branchT      idBranchType;
    logic        idPredTaken;
    logic [31:0] idPredTarget;
    logic        memValid;
    logic [31:0] memPc;
    logic [31:0] memResult;
    logic [4:0]  memDst;
    logic        memRegWr;
    logic        memOverflow;
    logic        predictionFailed;
    logic [31:0] correctionVector;
    logic        mulDivStall;

    entryT       stim[$];
    logic [31:0] modelHi = '0;
    logic [31:0] modelLo = '0;
    logic [31:0] pcNext = 32'h0040_0000;
    integer      seed = 32'hc358_982e;
    int          valueErrors = 0;
    int          otherErrors = 0;
    int          cycles = 0;
    int          cycleLimit = 0;

    exeTop #(.mulDivCycles(mulDivCycles)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycleLimit > 0 && cycles > cycleLimit) begin
            $display("timeout after %0d cycles, no result reached the mem stage", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [32:0] aluRef(input aluOpT op, input logic [31:0] a,
                                           input logic [31:0] b);
        logic [32:0] wide;
        logic [31:0] y;
        logic        ovf;
        wide = '0;
        y    = '0;
        ovf  = 1'b0;
        case (op)
            opAdd, opAddu: begin
                wide = {a[31], a} + {b[31], b};    // sign extended sum
                y    = wide[31:0];
                ovf  = (op == opAdd) && (wide[32] != wide[31]);
            end
            opSub, opSubu: begin
                wide = {a[31], a} - {b[31], b};
                y    = wide[31:0];
                ovf  = (op == opSub) && (wide[32] != wide[31]);
            end
            opAnd:   y = a & b;
            opOr:    y = a | b;
            opXor:   y = a ^ b;
            opNor:   y = ~(a | b);
            opSlt:   y = {31'b0, $signed(a) < $signed(b)};
            opSltu:  y = {31'b0, a < b};
            opSll:   y = b << a[4:0];
            opSrl:   y = b >> a[4:0];
            opSra:   y = $unsigned($signed(b) >>> a[4:0]);
            opLui:   y = {b[15:0], 16'h0000};
            default: y = '0;
        endcase
        return {ovf, y};
    endfunction

    // {failed, correction} for a valid instruction
    function automatic logic [32:0] branchRef(input entryT e);
        logic        taken;
        logic [31:0] target;
        case (e.br)
            brBeq:   taken = (e.a == e.b);
            brBne:   taken = (e.a != e.b);
            brJump:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
        target = (e.br == brJump) ? e.a : e.pc + 32'd4 + {e.imm[29:0], 2'b00};
        return {(taken != e.predTaken) || (taken && (target != e.predTarget)),
                taken ? target : e.pc + 32'd8};
    endfunction

    function automatic entryT newEntry();
        entryT e;
        e        = '0;
        e.op     = opAddu;
        e.pc     = pcNext;
        e.rd     = 5'(stim.size() + 1);
        e.rt     = 5'(stim.size() + 17);
        e.regWr  = 1'b1;
        e.chkRes = 1'b1;
        return e;
    endfunction

    task automatic addEntry(input entryT e);
        logic [32:0] aluOut;
        logic [32:0] brOut;
        logic [31:0] opA;
        logic [31:0] opB;
        logic        isMulDiv;
        isMulDiv = (e.op == opMult) || (e.op == opDiv);
        opA      = e.useShamt ? {27'b0, e.shamt} : e.a;
        opB      = e.srcBImm ? e.imm : e.b;
        aluOut   = aluRef(e.op, opA, opB);
        brOut    = branchRef(e);
        case (e.wbSel)
            wbHi:     e.expResult = modelHi;
            wbLo:     e.expResult = modelLo;
            wbPcAdd8: e.expResult = e.pc + 32'd8;
            default:  e.expResult = aluOut[31:0];
        endcase
        case (e.dstSel)
            dstRt:   e.expDst = e.rt;
            dstRa:   e.expDst = 5'd31;
            default: e.expDst = e.rd;
        endcase
        e.expOvf      = aluOut[32];
        e.expRegWr    = e.regWr && !aluOut[32] && !isMulDiv;
        e.expPredFail = brOut[32];
        e.expCorr     = brOut[31:0];
        e.expStall    = isMulDiv;
        if (e.flushAt == 0) begin    // an aborted op leaves hi/lo alone
            if (e.op == opMult) begin
                {modelHi, modelLo} = {32'b0, e.a} * {32'b0, e.b};
            end else if (e.op == opDiv && e.b == 0) begin
                modelHi = e.a;
                modelLo = '1;
            end else if (e.op == opDiv) begin
                modelHi = e.a % e.b;
                modelLo = e.a / e.b;
            end
        end
        stim.push_back(e);
        pcNext += 32'd4;
    endtask

    task automatic addAlu(input aluOpT op, input logic [31:0] a, input logic [31:0] b);
        entryT e;
        e    = newEntry();
        e.op = op;
        e.a  = a;
        e.b  = b;
        addEntry(e);
    endtask

    task automatic addImm(input aluOpT op, input logic [31:0] a, input logic [31:0] imm);
        entryT e;
        e         = newEntry();
        e.op      = op;
        e.a       = a;
        e.imm     = imm;
        e.srcBImm = 1'b1;
        e.dstSel  = dstRt;
        addEntry(e);
    endtask

    task automatic addShift(input aluOpT op, input logic [4:0] sa, input logic [31:0] b);
        entryT e;
        e          = newEntry();
        e.op       = op;
        e.shamt    = sa;
        e.a        = 32'hdead_bee0;    // must be ignored
        e.b        = b;
        e.useShamt = 1'b1;
        addEntry(e);
    endtask

    task automatic addBranch(input branchT br, input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] imm, input logic predTaken,
                             input logic [31:0] predTarget);
        entryT e;
        e            = newEntry();
        e.br         = br;
        e.a          = a;
        e.b          = b;
        e.imm        = imm;
        e.predTaken  = predTaken;
        e.predTarget = predTarget;
        e.regWr      = (br == brJump);    // jump links to ra
        e.dstSel     = dstRa;
        e.wbSel      = (br == brJump) ? wbPcAdd8 : wbAlu;
        addEntry(e);
    endtask

    task automatic addMulDiv(input aluOpT op, input logic [31:0] a, input logic [31:0] b,
                             input int flushAt);
        entryT e;
        e         = newEntry();
        e.op      = op;
        e.a       = a;
        e.b       = b;
        e.flushAt = flushAt;
        e.chkRes  = 1'b0;
        addEntry(e);
    endtask

    task automatic addMove(input wbSelT sel);
        entryT e;
        e       = newEntry();
        e.wbSel = sel;
        addEntry(e);
    endtask

    task automatic applyEntry(input entryT e);
        idValid      = 1'b1;
        idPc         = e.pc;
        idBusA       = e.a;
        idBusB       = e.b;
        idImm32      = e.imm;
        idShamt      = e.shamt;
        idRt         = e.rt;
        idRd         = e.rd;
        idAluOp      = e.op;
        idSrcBImm    = e.srcBImm;
        idUseShamt   = e.useShamt;
        idDstSel     = e.dstSel;
        idWbSel      = e.wbSel;
        idRegWr      = e.regWr;
        idBranchType = e.br;
        idPredTaken  = e.predTaken;
        idPredTarget = e.predTarget;
        exeWr        = 1'b1;
    endtask

    task automatic compareValue(input int idx, input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            valueErrors++;
            $display("Error %s at entry %0d: got %h, expected %h", name, idx, got, exp);
        end
    endtask

    task automatic buildStimulus();
        logic [31:0] a;
        logic [31:0] b;
        addAlu(opAdd, 32'd5, 32'd7);
        addAlu(opAddu, 32'hffff_fff0, 32'h0000_0020);
        addAlu(opSub, 32'd100, 32'd250);
        addAlu(opSubu, 32'h1234_5678, 32'h0000_5678);
        addAlu(opAnd, 32'hf0f0_a5a5, 32'h0ff0_ffff);
        addAlu(opOr, 32'hf000_0001, 32'h000f_0010);
        addAlu(opXor, 32'haaaa_5555, 32'hffff_0000);
        addAlu(opNor, 32'h0f0f_0000, 32'h00f0_0f00);
        addAlu(opSlt, 32'hffff_fffe, 32'd3);
        addAlu(opSltu, 32'hffff_fffe, 32'd3);
        addShift(opSll, 5'd4, 32'h8000_00f1);
        addShift(opSrl, 5'd12, 32'h8765_4321);
        addShift(opSra, 5'd31, 32'h8000_0000);
        addImm(opLui, 32'd0, 32'h0000_1234);
        addImm(opAddu, 32'h0000_1000, 32'hffff_fffc);
        addImm(opOr, 32'h00ff_0000, 32'h0000_00ff);
        // signed overflow pairs
        addAlu(opAdd, 32'h7fff_ffff, 32'd1);
        addAlu(opAddu, 32'h7fff_ffff, 32'd1);
        addAlu(opSub, 32'h8000_0000, 32'd1);
        addAlu(opSubu, 32'h8000_0000, 32'd1);
        addAlu(opAdd, 32'h8000_0000, 32'h8000_0000);
        addBranch(brBeq, 32'd9, 32'd9, 32'd16, 1'b1, pcNext + 32'd68);
        addBranch(brBeq, 32'd9, 32'd9, 32'hffff_fff8, 1'b0, 32'd0);
        addBranch(brBne, 32'd4, 32'd4, 32'd8, 1'b0, 32'd0);
        addBranch(brBne, 32'd4, 32'd5, 32'd8, 1'b1, 32'h0000_1000);
        addBranch(brBeq, 32'd1, 32'd2, 32'd3, 1'b1, pcNext + 32'd16);
        addBranch(brJump, 32'h0040_2000, 32'd0, 32'd0, 1'b1, 32'h0040_2000);
        addBranch(brJump, 32'h0040_3000, 32'd0, 32'd0, 1'b0, 32'd0);
        addBranch(brJump, 32'h0040_3000, 32'd0, 32'd0, 1'b1, 32'h0040_3004);
        a = $random(seed);
        b = $random(seed);
        addMulDiv(opMult, a, b, 0);
        addMove(wbHi);
        addMove(wbLo);
        a = $random(seed);
        b = $random(seed);
        b = b >> 14;                    // keeps the quotient interesting
        addMulDiv(opDiv, a, b, 0);
        addMove(wbHi);
        addMove(wbLo);
        addMulDiv(opDiv, 32'h1357_9bdf, 32'd0, 0);
        addMove(wbHi);
        addMove(wbLo);
        addMulDiv(opMult, 32'hffff_ffff, 32'hffff_ffff, 0);
        addMove(wbHi);
        addMove(wbLo);
        a = $random(seed);
        addMulDiv(opDiv, a, 32'd7, 5);    // flushed mid way
        addMove(wbHi);
        addMove(wbLo);
    endtask

    initial begin
        entryT e;
        arstN        = 1'b0;
        exeFlush     = 1'b0;
        exeWr        = 1'b0;
        idValid      = 1'b0;
        idPc         = '0;
        idBusA       = '0;
        idBusB       = '0;
        idImm32      = '0;
        idShamt      = '0;
        idRt         = '0;
        idRd         = '0;
        idAluOp      = opAddu;
        idSrcBImm    = 1'b0;
        idUseShamt   = 1'b0;
        idDstSel     = dstRd;
        idWbSel      = wbAlu;
        idRegWr      = 1'b0;
        idBranchType = brNone;
        idPredTaken  = 1'b0;
        idPredTarget = '0;
        buildStimulus();
        cycleLimit = stim.size() * (mulDivCycles + 6) + 8;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        for (int i = 0; i < stim.size(); i++) begin
            e = stim[i];
            applyEntry(e);
            @(posedge clk);
            @(negedge clk);
            compareValue(i, "predictionFailed", 32'(predictionFailed), 32'(e.expPredFail));
            compareValue(i, "correctionVector", correctionVector, e.expCorr);
            compareValue(i, "mulDivStall", 32'(mulDivStall), 32'(e.expStall));
            idValid = 1'b0;
            exeWr   = !mulDivStall;
            if (e.flushAt > 0) begin
                repeat (e.flushAt) @(negedge clk);
                exeFlush = 1'b1;
                @(negedge clk);
                exeFlush = 1'b0;
                exeWr    = 1'b1;
                repeat (mulDivCycles + 2) begin
                    @(negedge clk);
                    if (memValid) begin
                        otherErrors++;
                        $display("flushed divide at entry %0d still reached the mem stage", i);
                    end
                end
            end else begin
                while (!memValid) begin
                    @(negedge clk);
                    exeWr = !mulDivStall;    // hold upstream during mul/div
                end
                compareValue(i, "memPc", memPc, e.pc);
                if (e.chkRes) begin
                    compareValue(i, "memResult", memResult, e.expResult);
                end
                compareValue(i, "memDst", 32'(memDst), 32'(e.expDst));
                compareValue(i, "memRegWr", 32'(memRegWr), 32'(e.expRegWr));
                compareValue(i, "memOverflow", 32'(memOverflow), 32'(e.expOvf));
            end
        end
        $display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- tb/exeTop_asserts.sv
module exeTopAsserts (
    input logic clk,
    input logic arstN,
    input logic exeFlush,
    input logic start,
    input logic busy,
    input logic done,
    input logic mulDivStall,
    input logic memValid,
    input logic exValid
);

    timeunit 1ns;
    timeprecision 100ps;

    // busy has already dropped when done pulses
    assert property (@(posedge clk) disable iff (!arstN) done |=> !busy)
        else $error("busy still high after done");

    // the unit accepts every request
    assert property (@(posedge clk) disable iff (!arstN) start |=> busy)
        else $error("busy did not rise after start");

    // a stall cycle pushes a bubble into EXE/MEM
    assert property (@(posedge clk) disable iff (!arstN) mulDivStall |=> !memValid)
        else $error("memValid high after a stall cycle");

    // flush aborts mul/div and empties ID/EXE
    assert property (@(posedge clk) disable iff (!arstN) exeFlush |=> !busy && !exValid)
        else $error("unit busy or ID/EXE valid after a flush");

endmodule

bind exeTop exeTopAsserts uAsserts (
    .clk         (clk),
    .arstN       (arstN),
    .exeFlush    (exeFlush),
    .start       (mdBus.start),
    .busy        (mdBus.busy),
    .done        (mdBus.done),
    .mulDivStall (mulDivStall),
    .memValid    (memValid),
    .exValid     (exIn.valid)
);
